// ==== vchess_pkg.sv ====
package vchess_pkg;

   typedef logic [3:0]         piece_t;   // Bit 3 set for black.
   typedef logic [255:0]       board_t;   // Square n at bits 4n+3:4n, a1 first.
   typedef logic signed [15:0] score_t;   // Centipawns.

   // Piece type codes in the low three bits of a square.
   localparam logic [2:0] type_empty  = 3'd0;
   localparam logic [2:0] type_pawn   = 3'd1;
   localparam logic [2:0] type_knight = 3'd2;
   localparam logic [2:0] type_bishop = 3'd3;
   localparam logic [2:0] type_rook   = 3'd4;
   localparam logic [2:0] type_queen  = 3'd5;
   localparam logic [2:0] type_king   = 3'd6;

   localparam score_t val_pawn   = 16'sd100;
   localparam score_t val_knight = 16'sd320;
   localparam score_t val_bishop = 16'sd330;
   localparam score_t val_rook   = 16'sd500;
   localparam score_t val_queen  = 16'sd900;

   localparam score_t pv_bonus = 16'sd50;   // Move follows the PV.

   function automatic score_t piece_value(input logic [2:0] ptype);
      score_t value;
      case (ptype)
         type_pawn:   value = val_pawn;
         type_knight: value = val_knight;
         type_bishop: value = val_bishop;
         type_rook:   value = val_rook;
         type_queen:  value = val_queen;
         type_empty,
         type_king:   value = '0;
         default:     value = '0;      // Unused code 7.
      endcase
      return value;
   endfunction

endpackage

// ==== latency_sm.sv ====
`timescale 1ns/1ps

module latency_sm #(
   parameter int LATENCY_COUNT = 2
) (
   input  logic clk,
   input  logic rst_n,
   input  logic board_valid,
   input  logic clear_eval,
   output logic eval_valid
);

   localparam int CNT_W = $clog2(LATENCY_COUNT + 1);

   typedef enum logic [1:0] {st_idle, st_counting, st_valid} state_t;

   state_t           state;
   logic [CNT_W-1:0] cnt;
   logic             board_valid_r;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state         <= st_idle;
         cnt           <= '0;
         board_valid_r <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         if (clear_eval || !board_valid)
            state <= st_idle;
         else
         begin
            case (state)
               st_idle:
               begin
                  // Only a fresh board starts a count, a held level does not.
                  if (!board_valid_r)
                  begin
                     state <= st_counting;
                     cnt   <= CNT_W'(1);
                  end
               end
               st_counting:
               begin
                  if (cnt == CNT_W'(LATENCY_COUNT - 1))
                     state <= st_valid;
                  else
                     cnt <= cnt + 1'b1;
               end
               st_valid: state <= st_valid;   // Hold until clear or withdrawal.
               default:  state <= st_idle;
            endcase
         end
      end
   end

   assign eval_valid = (state == st_valid);

endmodule

// ==== evaluate_material.sv ====
`timescale 1ns/1ps

module evaluate_material
   import vchess_pkg::*;
#(
   parameter int LATENCY_COUNT = 3
) (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   board_valid,
   input  logic   clear_eval,
   input  board_t board,
   output score_t material,
   output logic   material_valid
);

   logic   board_valid_r;
   logic   new_board;
   logic   sum_load;       // Stage 1 holds fresh rank sums.
   piece_t square;
   score_t value;
   score_t rank_comb [8];
   score_t rank_sum  [8];
   score_t total_comb;

   assign new_board = board_valid && !board_valid_r;

   // Signed value of each rank, white positive.
   always_comb
   begin
      square = '0;
      value  = '0;
      for (int r = 0; r < 8; r++)
      begin
         rank_comb[r] = '0;
         for (int f = 0; f < 8; f++)
         begin
            square = board[4 * (8 * r + f) +: 4];
            value  = piece_value(square[2:0]);
            if (square[3])
               rank_comb[r] = rank_comb[r] - value;
            else
               rank_comb[r] = rank_comb[r] + value;
         end
      end
   end

   always_comb
   begin
      total_comb = '0;
      for (int r = 0; r < 8; r++)
         total_comb = total_comb + rank_sum[r];
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         board_valid_r <= 1'b0;
         sum_load      <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         sum_load      <= new_board;
      end
   end

   // Stage 1 on the new board, stage 2 a cycle later.
   always_ff @(posedge clk)
   begin
      if (new_board)
         rank_sum <= rank_comb;
      if (sum_load)
         material <= total_comb;
   end

   latency_sm #(
      .LATENCY_COUNT (LATENCY_COUNT)
   ) latency_sm_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (material_valid)
   );

endmodule

// ==== evaluate_pv.sv ====
`timescale 1ns/1ps

module evaluate_pv #(
   parameter int UCI_WIDTH      = 16,
   parameter int MAX_DEPTH_LOG2 = 5,
   parameter int LATENCY_COUNT  = 2
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      board_valid,
   input  logic                      clear_eval,
   input  logic [UCI_WIDTH-1:0]      uci_in,
   input  logic [MAX_DEPTH_LOG2-1:0] pv_ply,
   input  logic [31:0]               pv_ctrl,
   output logic                      eval_pv_flag,
   output logic                      eval_valid
);

   localparam int MAX_DEPTH = 2 ** MAX_DEPTH_LOG2;

   logic [UCI_WIDTH-1:0] pv_table [MAX_DEPTH];
   logic [MAX_DEPTH-1:0] pv_table_valid;
   logic                 board_valid_r;

   // Control word fields.
   logic                      ctrl_write;
   logic [UCI_WIDTH-1:0]      ctrl_entry;
   logic [MAX_DEPTH_LOG2-1:0] ctrl_ply;
   logic                      ctrl_entry_valid;

   assign ctrl_write       = pv_ctrl[31];
   assign ctrl_entry       = pv_ctrl[UCI_WIDTH-1:0];
   assign ctrl_ply         = pv_ctrl[UCI_WIDTH +: MAX_DEPTH_LOG2];
   assign ctrl_entry_valid = pv_ctrl[UCI_WIDTH + MAX_DEPTH_LOG2];

   always_ff @(posedge clk)
   begin
      if (ctrl_write)
         pv_table[ctrl_ply] <= ctrl_entry;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pv_table_valid <= '0;
         board_valid_r  <= 1'b0;
         eval_pv_flag   <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         if (ctrl_write)
            pv_table_valid[ctrl_ply] <= ctrl_entry_valid;
         if (board_valid && !board_valid_r)
            eval_pv_flag <= pv_table_valid[pv_ply] && (pv_table[pv_ply] == uci_in);
      end
   end

   latency_sm #(
      .LATENCY_COUNT (LATENCY_COUNT)
   ) latency_sm_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (eval_valid)
   );

endmodule

// ==== eval_combine.sv ====
`timescale 1ns/1ps

module eval_combine
   import vchess_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   white_to_move,
   input  score_t material,
   input  logic   material_valid,
   input  logic   eval_pv_flag,
   input  logic   eval_valid,
   output score_t score,
   output logic   score_valid,
   output logic   pv_match
);

   logic   both_valid;
   score_t with_bonus;
   score_t oriented;

   assign both_valid = material_valid && eval_valid;

   always_comb
   begin
      if (eval_pv_flag)
         with_bonus = material + pv_bonus;
      else
         with_bonus = material;
      // Material is white-relative; flip it for black to move.
      if (white_to_move)
         oriented = with_bonus;
      else
         oriented = -with_bonus;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         score_valid <= 1'b0;
         pv_match    <= 1'b0;
      end
      else
      begin
         score_valid <= both_valid;
         pv_match    <= both_valid && eval_pv_flag;   // Only shown with a valid score.
      end
   end

   always_ff @(posedge clk)
   begin
      if (both_valid)
         score <= oriented;
   end

endmodule

// ==== eval_top.sv ====
`timescale 1ns/1ps

module eval_top
   import vchess_pkg::*;
#(
   parameter int UCI_WIDTH      = 16,
   parameter int MAX_DEPTH_LOG2 = 5
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  board_t                    board,
   input  logic                      white_to_move,
   input  logic [UCI_WIDTH-1:0]      uci_in,
   input  logic [MAX_DEPTH_LOG2-1:0] pv_ply,
   input  logic                      board_valid,
   input  logic                      clear_eval,
   input  logic [31:0]               pv_ctrl,
   output score_t                    score,
   output logic                      score_valid,
   output logic                      pv_match
);

   score_t material;
   logic   material_valid;
   logic   eval_pv_flag;
   logic   eval_valid;

   evaluate_material #(
      .LATENCY_COUNT (3)   // Two summing stages plus edge capture.
   ) evaluate_material_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .board_valid    (board_valid),
      .clear_eval     (clear_eval),
      .board          (board),
      .material       (material),
      .material_valid (material_valid)
   );

   evaluate_pv #(
      .UCI_WIDTH      (UCI_WIDTH),
      .MAX_DEPTH_LOG2 (MAX_DEPTH_LOG2),
      .LATENCY_COUNT  (2)
   ) evaluate_pv_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .board_valid  (board_valid),
      .clear_eval   (clear_eval),
      .uci_in       (uci_in),
      .pv_ply       (pv_ply),
      .pv_ctrl      (pv_ctrl),
      .eval_pv_flag (eval_pv_flag),
      .eval_valid   (eval_valid)
   );

   eval_combine eval_combine_inst (
      .clk            (clk),
      .rst_n          (rst_n),
      .white_to_move  (white_to_move),
      .material       (material),
      .material_valid (material_valid),
      .eval_pv_flag   (eval_pv_flag),
      .eval_valid     (eval_valid),
      .score          (score),
      .score_valid    (score_valid),
      .pv_match       (pv_match)
   );

endmodule

// ==== tb_eval.sv ====
`timescale 1ns/1ps

module tb_eval
   import vchess_pkg::*;
;

   localparam int NUM_TESTS = 5;

   logic        clk;
   logic        rst_n;
   board_t      board;
   logic        white_to_move;
   logic [15:0] uci_in;
   logic [4:0]  pv_ply;
   logic        board_valid;
   logic        clear_eval;
   logic [31:0] pv_ctrl;
   score_t      score;
   logic        score_valid;
   logic        pv_match;

   integer      seed = 12014;
   int          errors = 0;
   int          pass_count = 0;
   int          fail_count = 0;
   score_t      exp_score = '0;
   logic        exp_match = 1'b0;
   logic        expect_idle = 1'b0;    // Set while a cleared board is still held.
   logic [15:0] shadow_entry [32];
   logic        shadow_valid [32];

   eval_top #(
      .UCI_WIDTH      (16),
      .MAX_DEPTH_LOG2 (5)
   ) eval_top_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .board         (board),
      .white_to_move (white_to_move),
      .uci_in        (uci_in),
      .pv_ply        (pv_ply),
      .board_valid   (board_valid),
      .clear_eval    (clear_eval),
      .pv_ctrl       (pv_ctrl),
      .score         (score),
      .score_valid   (score_valid),
      .pv_match      (pv_match)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   a_score: assert property (@(posedge clk) disable iff (!rst_n)
      score_valid |-> score == exp_score)
      else
      begin
         $display("[ERROR] %0t: score %0d, expected %0d", $time, $sampled(score),
                  $sampled(exp_score));
         errors++;
      end

   a_match: assert property (@(posedge clk) disable iff (!rst_n)
      score_valid |-> pv_match == exp_match)
      else
      begin
         $display("[ERROR] %0t: pv_match %0b, expected %0b", $time, $sampled(pv_match),
                  $sampled(exp_match));
         errors++;
      end

   // Board seen on the edge four cycles back, and absent on the one before.
   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(score_valid) |-> $past(board_valid, 4) && !$past(board_valid, 5))
      else
      begin
         $display("[ERROR] %0t: score_valid rose without a 4 cycle latency", $time);
         errors++;
      end

   a_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (!board_valid && !$past(board_valid) && !$past(board_valid, 2))
         |-> !score_valid && !pv_match)
      else
      begin
         $display("[ERROR] %0t: score_valid or pv_match high with no board", $time);
         errors++;
      end

   a_clear: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(clear_eval, 2) || expect_idle) |-> !score_valid)
      else
      begin
         $display("[ERROR] %0t: score_valid high after clear_eval", $time);
         errors++;
      end

   function automatic logic model_match(input logic [15:0] uci, input logic [4:0] ply);
      return shadow_valid[ply] && (shadow_entry[ply] == uci);
   endfunction

   function automatic score_t model_score(input board_t b, input logic wtm,
                                          input logic [15:0] uci, input logic [4:0] ply);
      int         total;
      int         v;
      logic [3:0] sq;
      total = 0;
      for (int n = 0; n < 64; n++)
      begin
         sq = b[4*n +: 4];
         case (sq[2:0])
            3'd1:    v = 100;
            3'd2:    v = 320;
            3'd3:    v = 330;
            3'd4:    v = 500;
            3'd5:    v = 900;
            default: v = 0;
         endcase
         if (sq[3])
            total -= v;
         else
            total += v;
      end
      if (model_match(uci, ply))
         total += 50;
      if (!wtm)
         total = -total;
      return score_t'(total);
   endfunction

   // About half the squares empty, others pawn to king of either colour.
   task automatic make_board(output board_t b);
      logic [31:0] r;
      b = '0;
      for (int n = 0; n < 64; n++)
      begin
         r = $random(seed);
         if (!r[0])
            b[4*n +: 4] = {r[1], 3'(r[31:8] % 24'd6 + 24'd1)};
      end
   endtask

   task automatic write_pv(input logic [4:0] ply, input logic [15:0] entry,
                           input logic valid);
      logic [31:0] word;
      word        = 32'h8000_0000;
      word[15:0]  = entry;
      word[20:16] = ply;
      word[21]    = valid;
      @(posedge clk);
      pv_ctrl <= word;
      @(posedge clk);
      pv_ctrl <= 32'h0;
      shadow_entry[ply] = entry;
      shadow_valid[ply] = valid;
   endtask

   task automatic wait_score_valid(input logic level);
      int cycles;
      cycles = 0;
      while (score_valid !== level && cycles < 20)
      begin
         @(posedge clk);
         cycles++;
      end
      if (score_valid !== level)
      begin
         $display("Timed out after %0d cycles waiting for score_valid to become %0b",
                  cycles, level);
         errors++;
      end
   endtask

   task automatic start_board(input board_t b, input logic wtm, input logic [15:0] uci,
                              input logic [4:0] ply);
      exp_score = model_score(b, wtm, uci, ply);
      exp_match = model_match(uci, ply);
      @(posedge clk);
      board         <= b;
      white_to_move <= wtm;
      uci_in        <= uci;
      pv_ply        <= ply;
      board_valid   <= 1'b1;
      wait_score_valid(1'b1);
   endtask

   task automatic stop_board();
      repeat (2) @(posedge clk);   // Let the held score be checked.
      board_valid <= 1'b0;
      @(posedge clk);
      wait_score_valid(1'b0);
   endtask

   task automatic run_board(input board_t b, input logic wtm, input logic [15:0] uci,
                            input logic [4:0] ply);
      start_board(b, wtm, uci, ply);
      stop_board();
   endtask

   task automatic end_test(input string name, input int errors_before);
      if (errors == errors_before)
      begin
         pass_count++;
         $display("%-14s pass", name);
      end
      else
      begin
         fail_count++;
         $display("%-14s fail (%0d errors)", name, errors - errors_before);
      end
   endtask

   initial
   begin
      repeat (NUM_TESTS * 200) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin
      board_t b;
      int     err0;
      rst_n         = 1'b0;
      board         = '0;
      white_to_move = 1'b1;
      uci_in        = '0;
      pv_ply        = '0;
      board_valid   = 1'b0;
      clear_eval    = 1'b0;
      pv_ctrl       = '0;
      for (int i = 0; i < 32; i++)
      begin
         shadow_entry[i] = '0;
         shadow_valid[i] = 1'b0;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      err0 = errors;
      repeat (10) @(posedge clk);
      end_test("reset_idle", err0);

      err0 = errors;
      for (int i = 0; i < 20; i++)
      begin
         make_board(b);
         run_board(b, 1'($random(seed)), 16'($random(seed)), 5'($random(seed)));
      end
      end_test("material", err0);

      err0 = errors;
      write_pv(5'd3, 16'h1c24, 1'b1);
      write_pv(5'd7, 16'h0634, 1'b1);
      write_pv(5'd12, 16'h7b3e, 1'b1);
      write_pv(5'd30, 16'h2d45, 1'b1);
      make_board(b);
      run_board(b, 1'b1, shadow_entry[3], 5'd3);
      make_board(b);
      run_board(b, 1'b0, shadow_entry[7], 5'd7);
      make_board(b);
      run_board(b, 1'b1, shadow_entry[12], 5'd12);
      make_board(b);
      run_board(b, 1'b0, shadow_entry[30], 5'd30);
      make_board(b);
      run_board(b, 1'b1, shadow_entry[3] ^ 16'h0001, 5'd3);   // Move off by one bit.
      make_board(b);
      run_board(b, 1'b0, shadow_entry[7], 5'd12);
      end_test("pv_match", err0);

      err0 = errors;
      write_pv(5'd7, shadow_entry[7], 1'b0);
      make_board(b);
      run_board(b, 1'b1, shadow_entry[7], 5'd7);
      end_test("pv_invalid", err0);

      err0 = errors;
      make_board(b);
      start_board(b, 1'b0, shadow_entry[3], 5'd3);
      @(posedge clk);
      clear_eval <= 1'b1;
      @(posedge clk);
      clear_eval <= 1'b0;
      @(posedge clk);
      expect_idle = 1'b1;
      repeat (8) @(posedge clk);
      expect_idle = 1'b0;
      board_valid <= 1'b0;
      @(posedge clk);
      board_valid <= 1'b1;    // Fresh edge with the same board.
      wait_score_valid(1'b1);
      stop_board();
      end_test("clear_restart", err0);

      $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0 && errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== list.f ====
vchess_pkg.sv
latency_sm.sv
evaluate_material.sv
evaluate_pv.sv
eval_combine.sv
eval_top.sv
tb_eval.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the evaluator testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_eval -f list.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_eval > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
